/* dv/imgproc_checker.sv */
module imgproc_checker #(
	parameter int MSG_DEPTH = 128
) (
	input  logic                clk,
	input  logic                reset_n,
	input  imgproc_pkg::pixel_t source_data,
	input  logic                source_valid,
	input  logic                source_ready,
	input  logic                source_sop,
	input  logic                source_eop,
	input  logic                fifo_wr,
	input  logic [7:0]          fifo_used
);

	// failed assertion tally, watched by the testbench
	int fail_count = 0;

	// stalled beat must not move
	source_hold: assert property (@(posedge clk) disable iff (!reset_n)
		(source_valid && !source_ready) |=> (source_valid && $stable(source_data) &&
			$stable(source_sop) && $stable(source_eop)))
	else begin
		$error("source beat changed while stalled");
		fail_count++;
	end

	// one cycle of reset clears the output slice
	reset_idle: assert property (@(posedge clk) !reset_n |=> !source_valid)
	else begin
		$error("source_valid high after a reset cycle");
		fail_count++;
	end

	// writer checks room before starting a report
	no_full_write: assert property (@(posedge clk) disable iff (!reset_n)
		!(fifo_wr && (fifo_used == 8'(MSG_DEPTH))))
	else begin
		$error("message FIFO written while full");
		fail_count++;
	end

endmodule

bind eee_imgproc imgproc_checker #(.MSG_DEPTH(MSG_DEPTH)) chk (
	.clk(clk), .reset_n(reset_n),
	.source_data(source_data), .source_valid(source_valid), .source_ready(source_ready),
	.source_sop(source_sop), .source_eop(source_eop),
	.fifo_wr(fifo_wr), .fifo_used(fifo_used)
);

/* dv/tb_imgproc.sv */
module tb_imgproc;

	import imgproc_pkg::*;

	localparam int IMAGE_W = 8;
	localparam int IMAGE_H = 4;
	localparam int MSG_INTERVAL = 3;
	localparam int MSG_DEPTH = 16;
	// drive offset after the rising edge
	localparam int T_DRIVE = 2;

	logic        clk, reset_n, mode;
	logic        s_chipselect, s_read, s_write;
	logic [2:0]  s_address;
	logic [31:0] s_writedata, s_readdata;
	pixel_t      sink_data, source_data;
	logic        sink_valid, sink_ready, sink_sop, sink_eop;
	logic        source_valid, source_ready, source_sop, source_eop;

	// expected beats as {pixel, sop, eop}
	logic [25:0] exp_q [$];
	// expected report words still in the FIFO
	msg_word_t   msg_q [$];
	logic [15:0] lfsr = 16'd619;
	// model of previous-frame boxes
	int          rb_l, rb_r, rb_t, rb_b, yb_l, yb_r, yb_t, yb_b;
	int          frame_cnt = MSG_INTERVAL - 1;
	pixel_t      m_bb_col = RBB_COL_DEFAULT;
	logic [7:0]  m_status = 8'h00;
	logic [31:0] v;
	pixel_t      new_col;
	int          k;

	eee_imgproc #(.IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H), .MSG_INTERVAL(MSG_INTERVAL),
		.MSG_DEPTH(MSG_DEPTH)) uut (.*);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// random source and reference model
	////////////////////////////////////////////////////////////

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
		end
		return r;
	endfunction

	// pure red, pure yellow, grey or anything
	function automatic pixel_t pick_pixel();
		logic [7:0] g;
		case (take_bits(2))
			0: return 24'hff0000;
			1: return 24'hffff00;
			2: begin
				g = take_bits(8);
				return {g, g, g};
			end
			default: return pixel_t'(take_bits(24));
		endcase
	endfunction

	// hue rule, saturation rule, class colour or grey
	function automatic pixel_t class_ref(input pixel_t p, output logic red_det,
			output logic yel_det);
		int r, g, b, mx, mn, d, h, gr;
		logic sat;
		r = p[23:16];
		g = p[15:8];
		b = p[7:0];
		mx = (r > g) ? r : g;
		mx = (b > mx) ? b : mx;
		mn = (r < g) ? r : g;
		mn = (b < mn) ? b : mn;
		d = mx - mn;
		if (d == 0)
			h = 0;
		else if (mx == r)
			h = (g >= b) ? (g - b) * 43 / d : 255 - (b - g) * 43 / d;
		else if (mx == g)
			h = (b >= r) ? 85 + (b - r) * 43 / d : 85 - (r - b) * 43 / d;
		else
			h = (r >= g) ? 171 + (r - g) * 43 / d : 171 - (g - r) * 43 / d;
		sat = (mx >= VALUE_MIN) && (4 * d >= 3 * mx);
		red_det = sat && (h < RED_HUE_MAX);
		yel_det = sat && (h > YELLOW_HUE_MIN) && (h < YELLOW_HUE_MAX);
		gr = g / 2 + r / 4 + b / 4;
		if (red_det)
			return RED_COL;
		if (yel_det)
			return YELLOW_COL;
		return {gr[7:0], gr[7:0], gr[7:0]};
	endfunction

	// overlay from model box state, red edge drawn first
	function automatic pixel_t pixel_out_ref(input pixel_t p, input int x, input int y,
			input bit video);
		logic rd, yd;
		pixel_t c;
		c = class_ref(p, rd, yd);
		if (!mode || !video)
			return p;
		if (x == rb_l || x == rb_r || y == rb_t || y == rb_b)
			return m_bb_col;
		if (x == yb_l || x == yb_r || y == yb_t || y == yb_b)
			return YELLOW_COL;
		return c;
	endfunction

	// tag, pad, first edge, pad, second edge
	function automatic logic [31:0] box_word(input msg_tag_t tag, input int a, input int b);
		return {tag, 1'b0, coord_t'(a), 5'b0, coord_t'(b)};
	endfunction

	// interval count and five-word report after each video frame
	function automatic void frame_report();
		if (frame_cnt == 0 && msg_q.size() < MSG_DEPTH - MSG_WORDS) begin
			msg_q.push_back({TAG_FLAGS, 26'd0, yb_r >= yb_l, rb_r >= rb_l});
			msg_q.push_back(box_word(TAG_RED_TB, rb_t, rb_b));
			msg_q.push_back(box_word(TAG_RED_LR, rb_l, rb_r));
			msg_q.push_back(box_word(TAG_YEL_TB, yb_t, yb_b));
			msg_q.push_back(box_word(TAG_YEL_LR, yb_l, yb_r));
			frame_cnt = MSG_INTERVAL - 1;
		end else begin
			frame_cnt--;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_pixel(input string what, input pixel_t got, input pixel_t exp);
		if (got !== exp)
			report_failure($sformatf("Error at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_word(input string what, input msg_word_t got, input msg_word_t exp);
		if (got !== exp)
			report_failure($sformatf("Error at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_reg(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("Error at time %0t: %s reads %h, expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Error at time %0t: %s is %b, expected %b",
				$time, what, got, exp));
	endtask

	// source beats in order against the queue
	always @(posedge clk) begin
		logic [25:0] e;
		if (reset_n && source_valid && source_ready) begin
			if (exp_q.size() == 0) begin
				report_failure("a source beat came out with none expected");
			end else begin
				e = exp_q.pop_front();
				check_pixel("source_data", source_data, e[25:2]);
				check_bit("source_sop", source_sop, e[1]);
				check_bit("source_eop", source_eop, e[0]);
			end
		end
	end

	// stop at the first stream or FIFO assertion failure
	always @(posedge clk) begin
		if (uut.chk.fail_count != 0)
			report_failure("a stream or FIFO assertion failed");
	end

	// random back-pressure, low about a quarter of the time
	always @(negedge clk) begin
		logic [1:0] bp;
		bp = take_bits(2);
		@(posedge clk);
		#T_DRIVE;
		source_ready = (bp != 0);
	end

	////////////////////////////////////////////////////////////
	// stream and slave drivers
	////////////////////////////////////////////////////////////

	task automatic drive_beat(input pixel_t d, input logic sop, input logic eop);
		int i;
		bit ok;
		// occasional idle cycle on the sink
		if (take_bits(3) == 0) begin
			sink_valid = 1'b0;
			@(posedge clk);
			#T_DRIVE;
		end
		sink_valid = 1'b1;
		sink_data = d;
		sink_sop = sop;
		sink_eop = eop;
		ok = 0;
		for (i = 0; i < 200 && !ok; i++) begin
			@(posedge clk);
			ok = sink_ready;
		end
		if (!ok)
			report_failure("sink_ready stayed low, the stream is stuck");
		#T_DRIVE;
		sink_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int i;
		for (i = 0; i < 2000 && exp_q.size() != 0; i++) begin
			@(posedge clk);
			#T_DRIVE;
		end
		if (exp_q.size() != 0)
			report_failure("the source stream did not deliver every expected beat");
	endtask

	// descriptor plus pixels, then model box and report update
	task automatic send_packet(input bit video, input int n_pix);
		pixel_t pix [$];
		pixel_t desc, p;
		logic rd, yd;
		int i, x, y;
		int rl, rr, rt, rbt, yl, yr, yt, ybt;
		desc = pixel_t'(take_bits(24));
		desc[3:0] = video ? 4'h0 : 4'h9;
		exp_q.push_back({desc, 2'b10});
		for (i = 0; i < n_pix; i++) begin
			p = pick_pixel();
			pix.push_back(p);
			exp_q.push_back({pixel_out_ref(p, i % IMAGE_W, i / IMAGE_W, video), 1'b0,
				i == n_pix - 1});
		end
		drive_beat(desc, 1'b1, 1'b0);
		for (i = 0; i < n_pix; i++)
			drive_beat(pix[i], 1'b0, i == n_pix - 1);
		wait_drain();
		if (video) begin
			rl = IMAGE_W - 1;
			rr = 0;
			rt = IMAGE_H - 1;
			rbt = 0;
			yl = IMAGE_W - 1;
			yr = 0;
			yt = IMAGE_H - 1;
			ybt = 0;
			// eop pixel is not part of the box
			for (i = 0; i < n_pix - 1; i++) begin
				void'(class_ref(pix[i], rd, yd));
				x = i % IMAGE_W;
				y = i / IMAGE_W;
				if (rd) begin
					rl = (x < rl) ? x : rl;
					rr = (x > rr) ? x : rr;
					rt = (y < rt) ? y : rt;
					rbt = (y > rbt) ? y : rbt;
				end
				if (yd) begin
					yl = (x < yl) ? x : yl;
					yr = (x > yr) ? x : yr;
					yt = (y < yt) ? y : yt;
					ybt = (y > ybt) ? y : ybt;
				end
			end
			{rb_l, rb_r, rb_t, rb_b} = {rl, rr, rt, rbt};
			{yb_l, yb_r, yb_t, yb_b} = {yl, yr, yt, ybt};
			frame_report();
		end
	endtask

	task automatic reg_write(input logic [2:0] a, input logic [31:0] d);
		s_chipselect = 1'b1;
		s_write = 1'b1;
		s_address = a;
		s_writedata = d;
		@(posedge clk);
		#T_DRIVE;
		s_chipselect = 1'b0;
		s_write = 1'b0;
		@(posedge clk);
		#T_DRIVE;
	endtask

	// one-cycle strobe, then an idle cycle so the next read pops again
	task automatic reg_read(input logic [2:0] a, output logic [31:0] d);
		s_chipselect = 1'b1;
		s_read = 1'b1;
		s_address = a;
		@(posedge clk);
		#T_DRIVE;
		s_chipselect = 1'b0;
		s_read = 1'b0;
		d = s_readdata;
		@(posedge clk);
		#T_DRIVE;
	endtask

	task automatic wait_fifo_words(input int n);
		logic [31:0] r;
		int i;
		bit seen;
		seen = 0;
		for (i = 0; i < 100 && !seen; i++) begin
			reg_read(REG_STATUS, r);
			seen = (r[15:8] == n);
		end
		if (!seen)
			report_failure($sformatf("the message FIFO never held %0d words", n));
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		mode = 1'b0;
		{s_chipselect, s_read, s_write} = 3'b000;
		s_address = '0;
		s_writedata = '0;
		sink_data = '0;
		{sink_valid, sink_sop, sink_eop} = 3'b000;
		source_ready = 1'b0;
		repeat (4) @(posedge clk);
		#T_DRIVE;
		reset_n = 1'b1;
		@(posedge clk);
		#T_DRIVE;

		reg_read(REG_ID, v);
		check_reg("REG_ID", v, DEVICE_ID);
		reg_read(REG_BBCOL, v);
		check_reg("REG_BBCOL", v, {8'h00, m_bb_col});

		// pass-through, then overlay with a non-video packet between
		send_packet(1'b1, IMAGE_W * IMAGE_H);
		send_packet(1'b0, 6);
		mode = 1'b1;
		send_packet(1'b0, 6);
		send_packet(1'b1, IMAGE_W * IMAGE_H);
		send_packet(1'b1, IMAGE_W * IMAGE_H);

		// first report
		wait_fifo_words(msg_q.size());
		reg_read(REG_STATUS, v);
		check_reg("REG_STATUS", v, {16'h0, 8'(MSG_WORDS), m_status});
		for (k = 0; k < MSG_WORDS; k++) begin
			reg_read(REG_MSG, v);
			check_word("report word", msg_word_t'(v), msg_q.pop_front());
		end
		reg_read(REG_STATUS, v);
		check_reg("REG_STATUS", v, {16'h0, 8'h00, m_status});

		// new red box colour on the following frames
		new_col = pixel_t'(take_bits(24));
		reg_write(REG_BBCOL, {8'ha5, new_col});
		m_bb_col = new_col;
		reg_read(REG_BBCOL, v);
		check_reg("REG_BBCOL", v, {8'h00, new_col});
		// three reports fit, the fourth is skipped for lack of room
		for (k = 0; k < 4 * MSG_INTERVAL; k++)
			send_packet(1'b1, IMAGE_W * IMAGE_H);

		// fill, then flush through status bit 4
		wait_fifo_words(msg_q.size());
		reg_read(REG_STATUS, v);
		check_reg("REG_STATUS", v, {16'h0, 8'(3 * MSG_WORDS), m_status});
		reg_write(REG_STATUS, 32'h15);
		msg_q.delete();
		m_status = 8'h15;
		reg_read(REG_STATUS, v);
		check_reg("REG_STATUS", v, {16'h0, 8'h00, m_status});

		if (uut.chk.fail_count == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			report_failure("a stream or FIFO assertion failed during the run");
		end
	end

endmodule

/* verilog.f */
verilog/imgproc_pkg.sv
verilog/stream_reg.sv
verilog/colour_classify.sv
verilog/box_tracker.sv
verilog/msg_fifo.sv
verilog/msg_writer.sv
verilog/mm_regs.sv
verilog/eee_imgproc.sv
dv/imgproc_checker.sv
dv/tb_imgproc.sv

/* verilog/box_tracker.sv */
module box_tracker #(
	parameter int IMAGE_W = 640,
	parameter int IMAGE_H = 480
) (
	input  logic                clk,
	input  logic                pixel_accept,
	input  logic                sop,
	input  logic                eop,
	input  logic                video,
	input  logic                detect,
	input  imgproc_pkg::coord_t x,
	input  imgproc_pkg::coord_t y,
	output imgproc_pkg::coord_t left,
	output imgproc_pkg::coord_t right,
	output imgproc_pkg::coord_t top,
	output imgproc_pkg::coord_t bottom
);

	import imgproc_pkg::*;

	// running bounds for the current frame
	coord_t x_min, x_max, y_min, y_max;

	////////////////////////////////////////////////////////////
	// per-frame bounds
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (pixel_accept & sop) begin
			// empty box, min above max
			x_min <= coord_t'(IMAGE_W - 1);
			x_max <= '0;
			y_min <= coord_t'(IMAGE_H - 1);
			y_max <= '0;
		end else if (pixel_accept & detect) begin
			if (x < x_min) begin
				x_min <= x;
			end
			if (x > x_max) begin
				x_max <= x;
			end
			if (y < y_min) begin
				y_min <= y;
			end
			// rows only grow inside a frame
			y_max <= y;
		end
	end

	////////////////////////////////////////////////////////////
	// box latch at end of video frame
	////////////////////////////////////////////////////////////

	// old bounds sampled, eop pixel itself left out
	always_ff @(posedge clk) begin
		if (pixel_accept & eop & video) begin
			left <= x_min;
			right <= x_max;
			top <= y_min;
			bottom <= y_max;
		end
	end

endmodule

/* verilog/colour_classify.sv */
module colour_classify (
	input  imgproc_pkg::pixel_t pixel,
	output logic                red_detect,
	output logic                yellow_detect,
	output imgproc_pkg::pixel_t class_colour
);

	import imgproc_pkg::*;

	logic [7:0] red, green, blue;
	logic [7:0] max_c, min_c, diff;
	logic [7:0] grey;
	// hue term operands
	logic [7:0] hi, lo, base, delta;
	logic       neg;
	logic [13:0] prod, quot;
	hue_t       hue;
	// saturation rule
	logic [9:0] diff_x4, max_x3;
	logic       sat_ok;

	assign {red, green, blue} = pixel;

	assign max_c = (red > green) ? ((red > blue) ? red : blue) : ((green > blue) ? green : blue);
	assign min_c = (red < green) ? ((red < blue) ? red : blue) : ((green < blue) ? green : blue);
	assign diff = max_c - min_c;

	////////////////////////////////////////////////////////////
	// hue, 43 steps per sixth of the circle
	////////////////////////////////////////////////////////////

	always_comb begin
		// pick the pair that sets the offset from the dominant colour
		if (max_c == red) begin
			hi = green;
			lo = blue;
			base = (green < blue) ? 8'd255 : 8'd0;
		end else if (max_c == green) begin
			hi = blue;
			lo = red;
			base = 8'd85;
		end else begin
			hi = red;
			lo = green;
			base = 8'd171;
		end
		neg = hi < lo;
		delta = neg ? (lo - hi) : (hi - lo);
		prod = delta * 14'd43;
		// guard the divider for grey pixels
		quot = (diff == 8'd0) ? 14'd0 : prod / diff;
		if (diff == 8'd0) begin
			hue = '0;
		end else if (neg) begin
			hue = base - quot[7:0];
		end else begin
			hue = base + quot[7:0];
		end
	end

	// diff >= 3/4 max, and bright enough
	assign diff_x4 = {diff, 2'b00};
	assign max_x3 = {2'b00, max_c} + {1'b0, max_c, 1'b0};
	assign sat_ok = (max_c >= VALUE_MIN) && (diff_x4 >= max_x3);

	assign red_detect = sat_ok && (hue < RED_HUE_MAX);
	assign yellow_detect = sat_ok && (hue > YELLOW_HUE_MIN) && (hue < YELLOW_HUE_MAX);

	// grey = g/2 + r/4 + b/4
	assign grey = {1'b0, green[7:1]} + {2'b00, red[7:2]} + {2'b00, blue[7:2]};

	// red wins over yellow
	always_comb begin
		if (red_detect) begin
			class_colour = RED_COL;
		end else if (yellow_detect) begin
			class_colour = YELLOW_COL;
		end else begin
			class_colour = {grey, grey, grey};
		end
	end

endmodule

/* verilog/eee_imgproc.sv */
module eee_imgproc #(
	parameter int IMAGE_W = 640,
	parameter int IMAGE_H = 480,
	parameter int MSG_INTERVAL = 6,
	parameter int MSG_DEPTH = 128
) (
	input  logic                clk,
	input  logic                reset_n,
	// mm slave
	input  logic                s_chipselect,
	input  logic                s_read,
	input  logic                s_write,
	input  logic [2:0]          s_address,
	input  logic [31:0]         s_writedata,
	output logic [31:0]         s_readdata,
	// stream sink
	input  imgproc_pkg::pixel_t sink_data,
	input  logic                sink_valid,
	output logic                sink_ready,
	input  logic                sink_sop,
	input  logic                sink_eop,
	// stream source
	output imgproc_pkg::pixel_t source_data,
	output logic                source_valid,
	input  logic                source_ready,
	output logic                source_sop,
	output logic                source_eop,
	// overlay enable
	input  logic                mode
);

	import imgproc_pkg::*;

	localparam int BEAT_W = $bits(pixel_t) + 2;

	logic [BEAT_W-1:0] in_beat, out_beat;
	pixel_t            pix_in, pix_out, class_colour, bb_col;
	logic              sop, eop, in_valid, out_ready, accept;
	coord_t            x, y;
	logic              packet_video, frame_done;
	logic              red_detect, yellow_detect, rbb_active, ybb_active;
	coord_t            red_left, red_right, red_top, red_bottom;
	coord_t            yellow_left, yellow_right, yellow_top, yellow_bottom;
	logic              fifo_wr, fifo_rd, fifo_empty, flush;
	msg_word_t         fifo_data, fifo_head;
	logic [7:0]        fifo_used;

	////////////////////////////////////////////////////////////
	// stream slices
	////////////////////////////////////////////////////////////

	stream_reg #(.DATA_W(BEAT_W)) in_slice (
		.clk(clk), .reset_n(reset_n),
		.valid_in(sink_valid), .data_in({sink_data, sink_sop, sink_eop}),
		.ready_out(sink_ready),
		.ready_in(out_ready), .valid_out(in_valid), .data_out(in_beat)
	);
	assign {pix_in, sop, eop} = in_beat;

	stream_reg #(.DATA_W(BEAT_W)) out_slice (
		.clk(clk), .reset_n(reset_n),
		.valid_in(in_valid), .data_in({pix_out, sop, eop}),
		.ready_out(out_ready),
		.ready_in(source_ready), .valid_out(source_valid), .data_out(out_beat)
	);
	assign {source_data, source_sop, source_eop} = out_beat;

	// beat moves from in_slice to out_slice
	assign accept = in_valid & out_ready;

	////////////////////////////////////////////////////////////
	// coordinates and packet type
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			x <= '0;
			y <= '0;
			packet_video <= 1'b0;
		end else if (accept) begin
			if (sop) begin
				x <= '0;
				y <= '0;
				// descriptor low nibble of blue is 0 for video
				packet_video <= (pix_in[3:0] == 4'h0);
			end else if (x == coord_t'(IMAGE_W - 1)) begin
				x <= '0;
				y <= y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	assign frame_done = accept & eop & packet_video;

	////////////////////////////////////////////////////////////
	// classify, track, overlay
	////////////////////////////////////////////////////////////

	colour_classify colour_classify (
		.pixel(pix_in), .red_detect(red_detect), .yellow_detect(yellow_detect),
		.class_colour(class_colour)
	);

	box_tracker #(.IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H)) red_box (
		.clk(clk), .pixel_accept(accept), .sop(sop), .eop(eop), .video(packet_video),
		.detect(red_detect), .x(x), .y(y),
		.left(red_left), .right(red_right), .top(red_top), .bottom(red_bottom)
	);

	box_tracker #(.IMAGE_W(IMAGE_W), .IMAGE_H(IMAGE_H)) yellow_box (
		.clk(clk), .pixel_accept(accept), .sop(sop), .eop(eop), .video(packet_video),
		.detect(yellow_detect), .x(x), .y(y),
		.left(yellow_left), .right(yellow_right), .top(yellow_top), .bottom(yellow_bottom)
	);

	// previous frame box edges
	assign rbb_active = (x == red_left) | (x == red_right) | (y == red_top) | (y == red_bottom);
	assign ybb_active = (x == yellow_left) | (x == yellow_right) |
		(y == yellow_top) | (y == yellow_bottom);

	// descriptor and non-video data pass untouched
	always_comb begin
		if (!(mode & ~sop & packet_video)) begin
			pix_out = pix_in;
		end else if (rbb_active) begin
			pix_out = bb_col;
		end else if (ybb_active) begin
			pix_out = YELLOW_COL;
		end else begin
			pix_out = class_colour;
		end
	end

	////////////////////////////////////////////////////////////
	// reports and slave
	////////////////////////////////////////////////////////////

	msg_writer #(.MSG_INTERVAL(MSG_INTERVAL), .MSG_DEPTH(MSG_DEPTH)) msg_writer (
		.clk(clk), .reset_n(reset_n), .frame_done(frame_done), .fifo_used(fifo_used),
		.red_left(red_left), .red_right(red_right), .red_top(red_top),
		.red_bottom(red_bottom), .yellow_left(yellow_left), .yellow_right(yellow_right),
		.yellow_top(yellow_top), .yellow_bottom(yellow_bottom),
		.fifo_wr(fifo_wr), .fifo_data(fifo_data)
	);

	msg_fifo #(.MSG_DEPTH(MSG_DEPTH)) msg_fifo (
		.clk(clk), .clear(~reset_n | flush), .wr(fifo_wr), .wr_data(fifo_data),
		.rd(fifo_rd), .rd_data(fifo_head), .used(fifo_used), .empty(fifo_empty)
	);

	mm_regs mm_regs (
		.clk(clk), .reset_n(reset_n), .chipselect(s_chipselect), .read(s_read),
		.write(s_write), .address(s_address), .writedata(s_writedata),
		.fifo_data(fifo_head), .fifo_used(fifo_used), .fifo_empty(fifo_empty),
		.readdata(s_readdata), .fifo_rd(fifo_rd), .flush(flush), .bb_col(bb_col)
	);

endmodule

/* verilog/imgproc_pkg.sv */
package imgproc_pkg;

	////////////////////////////////////////////////////////////
	// pixel and coordinate types
	////////////////////////////////////////////////////////////

	localparam int COORD_W = 11;

	typedef logic [COORD_W-1:0] coord_t;
	// red in top byte, then green, then blue
	typedef logic [23:0] pixel_t;
	// hue on 0..255 scale
	typedef logic [7:0] hue_t;

	// classification thresholds
	localparam hue_t RED_HUE_MAX = 8'd21;
	localparam hue_t YELLOW_HUE_MIN = 8'd22;
	localparam hue_t YELLOW_HUE_MAX = 8'd53;
	// min brightness for any detection
	localparam logic [7:0] VALUE_MIN = 8'd56;

	// class and box colours
	localparam pixel_t RED_COL = 24'hff0000;
	localparam pixel_t YELLOW_COL = 24'hffff00;
	localparam pixel_t RBB_COL_DEFAULT = 24'hff0000;

	////////////////////////////////////////////////////////////
	// slave register map
	////////////////////////////////////////////////////////////

	localparam logic [2:0] REG_STATUS = 3'd0;
	localparam logic [2:0] REG_MSG = 3'd1;
	localparam logic [2:0] REG_ID = 3'd2;
	localparam logic [2:0] REG_BBCOL = 3'd3;

	localparam logic [31:0] DEVICE_ID = 32'h1234eee2;

	////////////////////////////////////////////////////////////
	// report words
	////////////////////////////////////////////////////////////

	localparam int MSG_WORDS = 5;

	typedef logic [3:0] msg_tag_t;
	localparam msg_tag_t TAG_FLAGS = 4'd0;
	localparam msg_tag_t TAG_RED_TB = 4'd1;
	localparam msg_tag_t TAG_RED_LR = 4'd2;
	localparam msg_tag_t TAG_YEL_TB = 4'd3;
	localparam msg_tag_t TAG_YEL_LR = 4'd4;

	// first word of each report
	typedef struct packed {
		msg_tag_t   tag;
		logic [25:0] zero;
		logic       yellow_seen;
		logic       red_seen;
	} msg_flags_t;

	// box edge pair, first edge in upper half
	typedef struct packed {
		msg_tag_t   tag;
		logic       pad_a;
		coord_t     first;
		logic [4:0] pad_b;
		coord_t     second;
	} msg_box_t;

	typedef union packed {
		msg_flags_t flags;
		msg_box_t   box;
	} msg_word_t;

endpackage

/* verilog/mm_regs.sv */
module mm_regs (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   chipselect,
	input  logic                   read,
	input  logic                   write,
	input  logic [2:0]             address,
	input  logic [31:0]            writedata,
	input  imgproc_pkg::msg_word_t fifo_data,
	input  logic [7:0]             fifo_used,
	input  logic                   fifo_empty,
	output logic [31:0]            readdata,
	output logic                   fifo_rd,
	output logic                   flush,
	output imgproc_pkg::pixel_t    bb_col
);

	import imgproc_pkg::*;

	logic [7:0] status_reg;
	// read strobe seen last cycle
	logic       read_d;

	////////////////////////////////////////////////////////////
	// register writes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			status_reg <= 8'h00;
			bb_col <= RBB_COL_DEFAULT;
		end else if (chipselect & write) begin
			if (address == REG_STATUS) begin
				status_reg <= writedata[7:0];
			end
			if (address == REG_BBCOL) begin
				bb_col <= writedata[23:0];
			end
		end
	end

	// bit 4 of a status write empties the FIFO
	assign flush = chipselect & write & (address == REG_STATUS) & writedata[4];

	////////////////////////////////////////////////////////////
	// read path
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			readdata <= 32'h0;
			read_d <= 1'b0;
		end else begin
			read_d <= chipselect & read;
			if (chipselect & read) begin
				case (address)
					REG_STATUS: readdata <= {16'h0, fifo_used, status_reg};
					REG_MSG: readdata <= fifo_data;
					REG_ID: readdata <= DEVICE_ID;
					REG_BBCOL: readdata <= {8'h00, bb_col};
					default: readdata <= 32'h0;
				endcase
			end
		end
	end

	// pop once per read, on its first cycle
	assign fifo_rd = chipselect & read & ~read_d & ~fifo_empty & (address == REG_MSG);

endmodule

/* verilog/msg_fifo.sv */
module msg_fifo #(
	parameter int MSG_DEPTH = 128
) (
	input  logic                   clk,
	input  logic                   clear,
	input  logic                   wr,
	input  imgproc_pkg::msg_word_t wr_data,
	input  logic                   rd,
	output imgproc_pkg::msg_word_t rd_data,
	output logic [7:0]             used,
	output logic                   empty
);

	import imgproc_pkg::*;

	localparam int PTR_W = $clog2(MSG_DEPTH);
	localparam int CNT_W = $clog2(MSG_DEPTH + 1);

	msg_word_t        mem [MSG_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr, do_rd;

	// circular increment
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(MSG_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign used = 8'(count);
	// drop writes when full, pops when empty
	assign do_wr = wr & (count != CNT_W'(MSG_DEPTH));
	assign do_rd = rd & ~empty;

	// show-ahead head word
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (do_wr & ~do_rd) begin
				count <= count + 1'b1;
			end else if (do_rd & ~do_wr) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

endmodule

/* verilog/msg_writer.sv */
module msg_writer #(
	parameter int MSG_INTERVAL = 6,
	parameter int MSG_DEPTH = 128
) (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   frame_done,
	input  logic [7:0]             fifo_used,
	input  imgproc_pkg::coord_t    red_left,
	input  imgproc_pkg::coord_t    red_right,
	input  imgproc_pkg::coord_t    red_top,
	input  imgproc_pkg::coord_t    red_bottom,
	input  imgproc_pkg::coord_t    yellow_left,
	input  imgproc_pkg::coord_t    yellow_right,
	input  imgproc_pkg::coord_t    yellow_top,
	input  imgproc_pkg::coord_t    yellow_bottom,
	output logic                   fifo_wr,
	output imgproc_pkg::msg_word_t fifo_data
);

	import imgproc_pkg::*;

	localparam int CNT_W = $clog2(MSG_INTERVAL) + 1;

	logic [CNT_W-1:0] frame_cnt;
	// 0 idle, 1..5 report word index
	logic [2:0]       state;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			frame_cnt <= CNT_W'(MSG_INTERVAL - 1);
			state <= 3'd0;
		end else begin
			if (state == 3'(MSG_WORDS)) begin
				state <= 3'd0;
			end else if (state != 3'd0) begin
				state <= state + 3'd1;
			end
			if (frame_done) begin
				// start only with room for a whole report
				if ((frame_cnt == '0) && (fifo_used < MSG_DEPTH - MSG_WORDS)) begin
					frame_cnt <= CNT_W'(MSG_INTERVAL - 1);
					state <= 3'd1;
				end else begin
					frame_cnt <= frame_cnt - 1'b1;
				end
			end
		end
	end

	assign fifo_wr = (state != 3'd0);

	////////////////////////////////////////////////////////////
	// report word mux
	////////////////////////////////////////////////////////////

	always_comb begin
		fifo_data = '0;
		case (state)
			3'd1: begin
				fifo_data.flags.tag = TAG_FLAGS;
				// empty box keeps right below left
				fifo_data.flags.yellow_seen = (yellow_right >= yellow_left);
				fifo_data.flags.red_seen = (red_right >= red_left);
			end
			3'd2: begin
				fifo_data.box.tag = TAG_RED_TB;
				fifo_data.box.first = red_top;
				fifo_data.box.second = red_bottom;
			end
			3'd3: begin
				fifo_data.box.tag = TAG_RED_LR;
				fifo_data.box.first = red_left;
				fifo_data.box.second = red_right;
			end
			3'd4: begin
				fifo_data.box.tag = TAG_YEL_TB;
				fifo_data.box.first = yellow_top;
				fifo_data.box.second = yellow_bottom;
			end
			3'd5: begin
				fifo_data.box.tag = TAG_YEL_LR;
				fifo_data.box.first = yellow_left;
				fifo_data.box.second = yellow_right;
			end
			default: begin
				fifo_data = '0;
			end
		endcase
	end

endmodule

/* verilog/stream_reg.sv */
module stream_reg #(
	parameter int DATA_W = 26
) (
	input  logic              clk,
	input  logic              reset_n,
	// upstream side
	input  logic              valid_in,
	input  logic [DATA_W-1:0] data_in,
	output logic              ready_out,
	// downstream side
	input  logic              ready_in,
	output logic              valid_out,
	output logic [DATA_W-1:0] data_out
);

	// can take a beat when empty or draining this cycle
	assign ready_out = ~valid_out | ready_in;

	// occupancy flag
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_out <= 1'b0;
		end else if (ready_out) begin
			valid_out <= valid_in;
		end
	end

	// payload
	// held under back-pressure since ready_out is low then
	always_ff @(posedge clk) begin
		if (ready_out) begin
			data_out <= data_in;
		end
	end

endmodule
